/* files.f */
sc_pkg.sv
sc_update_if.sv
sc_index.sv
sc_table.sv
sc_commit_queue.sv
sc_predict.sv
sc_updater.sv
sc_corrector.sv
sc_tb_clock.sv
sc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the SC testbench with Verilator, runs it and checks the log.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module sc_tb -f files.f --Mdir "$BUILD_DIR" -o sc_tb_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sc_tb_sim" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* sc_tb.sv */
`timescale 1ns/100ps

module sc_tb;
    import sc_pkg::*;

    localparam int TEST_COUNT = 5;
    localparam int CYCLES_PER_TEST = 800; // the longest test needs well under a hundred.
    localparam int TIMEOUT_CYCLES = TEST_COUNT * CYCLES_PER_TEST;
    localparam int CTR_HI = (1 << (CTR_SIZE - 1)) - 1;
    localparam int CTR_LO = -(1 << (CTR_SIZE - 1));
    localparam int THR_HI = (1 << THRESH_CTR) - 1;
    localparam int GTHR_HI = (1 << GTHRESH_CTR) - 1;

    logic clk;
    logic rst;
    logic stall;
    logic [VADDR_SIZE-1:0] pc;
    logic [GHIST_WIDTH-1:0] ghist;
    logic [SLOT_NUM-1:0][TAGE_CTR_SIZE-1:0] tage_ctr;
    logic [SLOT_NUM-1:0] tage_taken;
    logic [SLOT_NUM-1:0] prediction;
    sc_meta_t meta;
    logic update_valid;
    logic [VADDR_SIZE-1:0] update_pc;
    logic [GHIST_WIDTH-1:0] update_ghist;
    logic [SLOT_NUM-1:0] update_slot_mask;
    logic [SLOT_NUM-1:0] real_taken;
    sc_meta_t update_meta;

    // expected state of the rows that the training pc and history select.
    int m_ctr [TABLE_NUM][SLOT_NUM];
    int m_thr [SLOT_NUM];
    int m_gthr [SLOT_NUM];

    int errors;
    int test_start_errors;
    int failed_tests;
    int cycle_count;
    logic [VADDR_SIZE-1:0] train_pc;
    logic [GHIST_WIDTH-1:0] train_gh;
    logic [SLOT_NUM-1:0] last_pred;
    sc_meta_t last_meta;

    sc_tb_clock #(.PERIOD_NS(8.0), .RESET_CYCLES(8)) u_clock (.clk(clk), .rst(rst));

    sc_corrector #(.COMMIT_ENTRIES(4)) DUT (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .pc(pc),
        .ghist(ghist),
        .tage_ctr(tage_ctr),
        .tage_taken(tage_taken),
        .prediction(prediction),
        .meta(meta),
        .update_valid(update_valid),
        .update_pc(update_pc),
        .update_ghist(update_ghist),
        .update_slot_mask(update_slot_mask),
        .real_taken(real_taken),
        .update_meta(update_meta)
    );

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("** Error: %s = %h, expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_outputs(input logic [SLOT_NUM-1:0] exp_pred, input sc_meta_t exp_meta);
        check_value("prediction", prediction, exp_pred);
        check_value("meta.ctrs", meta.ctrs, exp_meta.ctrs);
        check_value("meta.pred_taken", meta.pred_taken, exp_meta.pred_taken);
        check_value("meta.thresh_ctr", meta.thresh_ctr, exp_meta.thresh_ctr);
        check_value("meta.thresh_update", meta.thresh_update, exp_meta.thresh_update);
    endtask

    // rows outside the trained index are still at their reset values.
    task automatic model_lookup(
        input bit trained_row,
        input logic [SLOT_NUM-1:0][TAGE_CTR_SIZE-1:0] tctr,
        input logic [SLOT_NUM-1:0] ttaken,
        output logic [SLOT_NUM-1:0] pred,
        output sc_meta_t m
    );
        int c;
        int sum;
        int mag;
        int thr;
        int lt;
        int tc;
        bit low;
        bit mid;
        bit use_sc;
        m = '0;
        for (int s = 0; s < SLOT_NUM; s++) begin
            sum = 0;
            mag = 0;
            for (int t = 0; t < TABLE_NUM; t++) begin
                c = trained_row ? m_ctr[t][s] : 0;
                sum += c;
                mag += (c >= 0) ? c : -c - 1;
                m.ctrs[t][s] = CTR_SIZE'(c);
            end
            thr = trained_row ? m_thr[s] : 0;
            lt = thr + m_gthr[s];
            tc = int'(tctr[s]);
            low = (tc == 3) || (tc == 4);
            mid = (tc == 2) || (tc == 5);
            use_sc = low || (mid && mag > lt / 4) || (!low && !mid && mag > lt / 2);
            m.thresh_ctr[s] = THRESH_CTR'(thr);
            m.pred_taken[s] = (sum >= 0);
            m.thresh_update[s] = (mag < lt);
            pred[s] = use_sc ? (sum >= 0) : ttaken[s];
        end
    endtask

    task automatic model_update(
        input logic [SLOT_NUM-1:0] mask,
        input logic [SLOT_NUM-1:0] taken,
        input sc_meta_t m
    );
        bit err;
        for (int s = 0; s < SLOT_NUM; s++) begin
            err = m.pred_taken[s] ^ taken[s];
            if (mask[s] && (err || m.thresh_update[s])) begin
                for (int t = 0; t < TABLE_NUM; t++) begin
                    if (taken[s] && m_ctr[t][s] < CTR_HI) m_ctr[t][s]++;
                    if (!taken[s] && m_ctr[t][s] > CTR_LO) m_ctr[t][s]--;
                end
                if (err) begin
                    m_thr[s] = (m_thr[s] < THR_HI) ? m_thr[s] + 1 : m_thr[s];
                    m_gthr[s] = (m_gthr[s] < GTHR_HI) ? m_gthr[s] + 1 : m_gthr[s];
                end else begin
                    m_thr[s] = (m_thr[s] > 0) ? m_thr[s] - 1 : m_thr[s];
                    m_gthr[s] = (m_gthr[s] > 0) ? m_gthr[s] - 1 : m_gthr[s];
                end
            end
        end
    endtask

    // the TAGE inputs follow the pc by one edge and the result lands two edges after it.
    task automatic lookup(
        input logic [VADDR_SIZE-1:0] lpc,
        input logic [GHIST_WIDTH-1:0] lgh,
        input bit trained_row,
        input logic [SLOT_NUM-1:0][TAGE_CTR_SIZE-1:0] tctr,
        input logic [SLOT_NUM-1:0] ttaken
    );
        model_lookup(trained_row, tctr, ttaken, last_pred, last_meta);
        @(posedge clk);
        pc <= lpc;
        ghist <= lgh;
        @(posedge clk);
        tage_ctr <= tctr;
        tage_taken <= ttaken;
        @(posedge clk);
        @(negedge clk);
        check_outputs(last_pred, last_meta);
    endtask

    task automatic send_update(
        input logic [SLOT_NUM-1:0] mask,
        input logic [SLOT_NUM-1:0] taken,
        input sc_meta_t m
    );
        @(posedge clk);
        update_valid <= 1'b1;
        update_pc <= train_pc;
        update_ghist <= train_gh;
        update_slot_mask <= mask;
        real_taken <= taken;
        update_meta <= m;
        model_update(mask, taken, m);
    endtask

    task automatic end_updates();
        @(posedge clk);
        update_valid <= 1'b0;
    endtask

    task automatic report_test(input int num, input string name);
        if (errors == test_start_errors) begin
            $display("test %0d %s: ok", num, name);
        end else begin
            failed_tests++;
            $display("test %0d %s: %0d errors", num, name, errors - test_start_errors);
        end
        test_start_errors = errors;
    endtask

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin : main_seq
        logic [VADDR_SIZE-1:0] rand_pc;
        logic [VADDR_SIZE-1:0] alt_pc;
        logic [GHIST_WIDTH-1:0] rand_gh;
        logic [SLOT_NUM-1:0] hold_pred;
        logic [SLOT_NUM-1:0] fetch_pred;
        sc_meta_t hold_meta;
        sc_meta_t fetch_meta;
        sc_meta_t stale_meta;

        void'($urandom(92502));
        stall = 1'b0;
        pc = '0;
        ghist = '0;
        tage_ctr = '0;
        tage_taken = '0;
        update_valid = 1'b0;
        update_pc = '0;
        update_ghist = '0;
        update_slot_mask = '0;
        real_taken = '0;
        update_meta = '0;
        errors = 0;
        failed_tests = 0;
        test_start_errors = 0;
        for (int s = 0; s < SLOT_NUM; s++) begin
            for (int t = 0; t < TABLE_NUM; t++) begin
                m_ctr[t][s] = 0;
            end
            m_thr[s] = 0;
            m_gthr[s] = GTHRESH_INIT;
        end
        train_pc = $urandom;
        train_gh = GHIST_WIDTH'($urandom);
        rand_pc = $urandom;
        rand_gh = GHIST_WIDTH'($urandom);
        // flipping the lowest hashed pc bit moves every index to a different row.
        alt_pc = train_pc ^ (VADDR_SIZE'(1) << INST_OFFSET);
        @(negedge rst);

        lookup(rand_pc, rand_gh, 1'b0, {3'd3, 3'd3}, 2'b00);
        lookup(rand_pc, rand_gh, 1'b0, {3'd7, 3'd0}, 2'b00);
        lookup(rand_pc, rand_gh, 1'b0, {3'd0, 3'd7}, 2'b00);
        report_test(1, "reset lookup");

        lookup(train_pc, train_gh, 1'b1, {3'd3, 3'd3}, 2'b00);
        stale_meta = last_meta;
        repeat (8) send_update(2'b11, 2'b00, stale_meta);
        end_updates();
        lookup(train_pc, train_gh, 1'b1, {3'd3, 3'd3}, 2'b11);
        report_test(2, "back-to-back updates");

        lookup(train_pc, train_gh, 1'b1, {3'd5, 3'd2}, 2'b11);
        lookup(train_pc, train_gh, 1'b1, {3'd7, 3'd0}, 2'b11);
        lookup(train_pc, train_gh, 1'b1, {3'd2, 3'd5}, 2'b11);
        report_test(3, "override rules");

        lookup(alt_pc, train_gh, 1'b0, {3'd3, 3'd3}, 2'b00);
        hold_pred = last_pred;
        hold_meta = last_meta;
        model_lookup(1'b1, {3'd3, 3'd3}, 2'b11, fetch_pred, fetch_meta);
        @(posedge clk);
        pc <= train_pc;
        ghist <= train_gh;
        @(posedge clk);
        tage_ctr <= {3'd3, 3'd3};
        tage_taken <= 2'b11;
        stall <= 1'b1;
        pc <= alt_pc; // the next fetch's pc must not reach the frozen table read.
        repeat (5) begin
            @(negedge clk);
            check_outputs(hold_pred, hold_meta);
        end
        @(posedge clk);
        stall <= 1'b0;
        @(posedge clk);
        @(negedge clk);
        check_outputs(fetch_pred, fetch_meta);
        report_test(4, "stall hold");

        lookup(train_pc, train_gh, 1'b1, {3'd0, 3'd0}, 2'b11);
        stale_meta = last_meta;
        repeat (3) send_update(2'b01, 2'b11, stale_meta);
        end_updates();
        lookup(train_pc, train_gh, 1'b1, {3'd5, 3'd2}, 2'b11);
        lookup(train_pc, train_gh, 1'b1, {3'd7, 3'd0}, 2'b11);
        report_test(5, "slot mask");

        $display("%0d tests run, %0d failed, %0d check errors", TEST_COUNT, failed_tests, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

/* sc_tb_clock.sv */
`timescale 1ns/100ps

module sc_tb_clock #(
    parameter real PERIOD_NS = 8.0,
    parameter int RESET_CYCLES = 8
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0; // released on an edge like the rest of the stimulus.
    end

endmodule

/* sc_corrector.sv */
`timescale 1ns/100ps

module sc_corrector #(
    parameter int COMMIT_ENTRIES = 4
) (
    input logic clk,
    input logic rst,
    input logic stall,
    input logic [sc_pkg::VADDR_SIZE-1:0] pc,
    input logic [sc_pkg::GHIST_WIDTH-1:0] ghist,
    input logic [sc_pkg::SLOT_NUM-1:0][sc_pkg::TAGE_CTR_SIZE-1:0] tage_ctr,
    input logic [sc_pkg::SLOT_NUM-1:0] tage_taken,
    output logic [sc_pkg::SLOT_NUM-1:0] prediction,
    output sc_pkg::sc_meta_t meta,
    input logic update_valid,
    input logic [sc_pkg::VADDR_SIZE-1:0] update_pc,
    input logic [sc_pkg::GHIST_WIDTH-1:0] update_ghist,
    input logic [sc_pkg::SLOT_NUM-1:0] update_slot_mask,
    input logic [sc_pkg::SLOT_NUM-1:0] real_taken,
    input sc_pkg::sc_meta_t update_meta
);
    import sc_pkg::*;

    sc_update_if upd ();

    ctr_row_t [TABLE_NUM-1:0] ctr_rows;
    thresh_row_t thresh_row;
    gthresh_row_t gthresh;
    logic [THRESH_IDX_WIDTH-1:0] thresh_idx;

    for (genvar i = 0; i < TABLE_NUM; i++) begin : g_tbl
        logic [TABLE_IDX_WIDTH-1:0] idx;

        sc_index #(
            .IDX_WIDTH(TABLE_IDX_WIDTH),
            .HIST_LEN(HIST_LEN[i])
        ) u_index (
            .pc(pc),
            .ghist(ghist),
            .idx(idx)
        );

        sc_table #(
            .DEPTH(1 << TABLE_IDX_WIDTH),
            .row_t(ctr_row_t),
            .RESET_VALUE('0),
            .TABLE_SEL(i)
        ) u_table (
            .clk(clk),
            .rst(rst),
            .en(~stall),
            .lookup_idx(idx),
            .lookup_row(ctr_rows[i]),
            .upd(upd)
        );
    end

    sc_index #(
        .IDX_WIDTH(THRESH_IDX_WIDTH),
        .HIST_LEN(0)
    ) u_thresh_index (
        .pc(pc),
        .ghist(ghist),
        .idx(thresh_idx)
    );

    // the selector past the counter tables binds the threshold write side.
    sc_table #(
        .DEPTH(1 << THRESH_IDX_WIDTH),
        .row_t(thresh_row_t),
        .RESET_VALUE('0),
        .TABLE_SEL(TABLE_NUM)
    ) u_thresh_table (
        .clk(clk),
        .rst(rst),
        .en(~stall),
        .lookup_idx(thresh_idx),
        .lookup_row(thresh_row),
        .upd(upd)
    );

    sc_predict u_predict (
        .clk(clk),
        .rst(rst),
        .stall(stall),
        .ctr_rows(ctr_rows),
        .thresh_row(thresh_row),
        .gthresh(gthresh),
        .tage_ctr(tage_ctr),
        .tage_taken(tage_taken),
        .prediction(prediction),
        .meta(meta)
    );

    sc_updater #(
        .COMMIT_ENTRIES(COMMIT_ENTRIES)
    ) u_updater (
        .clk(clk),
        .rst(rst),
        .update_valid(update_valid),
        .update_pc(update_pc),
        .update_ghist(update_ghist),
        .update_slot_mask(update_slot_mask),
        .real_taken(real_taken),
        .update_meta(update_meta),
        .gthresh(gthresh),
        .upd(upd)
    );

endmodule

/* sc_updater.sv */
`timescale 1ns/100ps

module sc_updater #(
    parameter int COMMIT_ENTRIES = 4
) (
    input logic clk,
    input logic rst,
    input logic update_valid,
    input logic [sc_pkg::VADDR_SIZE-1:0] update_pc,
    input logic [sc_pkg::GHIST_WIDTH-1:0] update_ghist,
    input logic [sc_pkg::SLOT_NUM-1:0] update_slot_mask,
    input logic [sc_pkg::SLOT_NUM-1:0] real_taken,
    input sc_pkg::sc_meta_t update_meta,
    output sc_pkg::gthresh_row_t gthresh,
    sc_update_if.updater upd
);
    import sc_pkg::*;

    localparam ctr_t CTR_MAX = ctr_t'({1'b0, {(CTR_SIZE-1){1'b1}}});
    localparam ctr_t CTR_MIN = ctr_t'({1'b1, {(CTR_SIZE-1){1'b0}}});

    logic [SLOT_NUM-1:0] pred_error;
    logic [SLOT_NUM-1:0] train;
    logic [THRESH_IDX_WIDTH-1:0] thresh_idx;
    logic thresh_hit;
    thresh_row_t thresh_cq_row;
    thresh_row_t thresh_base;
    thresh_row_t thresh_new;

    function automatic ctr_t ctr_step(input ctr_t c, input logic up);
        if (up) return (c == CTR_MAX) ? c : c + ctr_t'(1);
        return (c == CTR_MIN) ? c : c - ctr_t'(1);
    endfunction

    function automatic thresh_ctr_t thresh_step(input thresh_ctr_t v, input logic up);
        if (up) return (v == '1) ? v : v + 1'b1;
        return (v == '0) ? v : v - 1'b1;
    endfunction

    function automatic gthresh_ctr_t gthresh_step(input gthresh_ctr_t v, input logic up);
        if (up) return (v == '1) ? v : v + 1'b1;
        return (v == '0) ? v : v - 1'b1;
    endfunction

    assign pred_error = update_meta.pred_taken ^ real_taken;
    // train on a misprediction or when the sum was not confident enough.
    assign train = {SLOT_NUM{update_valid}} & update_slot_mask &
                   (pred_error | update_meta.thresh_update);
    assign upd.slot_en = train;

    for (genvar i = 0; i < TABLE_NUM; i++) begin : g_tbl
        logic [TABLE_IDX_WIDTH-1:0] idx;
        logic hit;
        ctr_row_t cq_row;
        ctr_row_t base_row;
        ctr_row_t new_row;

        sc_index #(
            .IDX_WIDTH(TABLE_IDX_WIDTH),
            .HIST_LEN(HIST_LEN[i])
        ) u_index (
            .pc(update_pc),
            .ghist(update_ghist),
            .idx(idx)
        );

        sc_commit_queue #(
            .ENTRIES(COMMIT_ENTRIES),
            .TAG_WIDTH(TABLE_IDX_WIDTH),
            .payload_t(ctr_row_t)
        ) u_queue (
            .clk(clk),
            .rst(rst),
            .we(|train),
            .wtag(idx),
            .wdata(new_row),
            .rtag(idx),
            .rhit(hit),
            .rdata(cq_row)
        );

        assign base_row = hit ? cq_row : update_meta.ctrs[i]; // metadata may be stale.

        always_comb begin
            for (int s = 0; s < SLOT_NUM; s++) begin
                new_row[s] = train[s] ? ctr_step(base_row[s], real_taken[s]) : base_row[s];
            end
        end

        assign upd.tbl_idx[i] = idx;
        assign upd.tbl_row[i] = new_row;
    end

    sc_index #(
        .IDX_WIDTH(THRESH_IDX_WIDTH),
        .HIST_LEN(0)
    ) u_thresh_index (
        .pc(update_pc),
        .ghist(update_ghist),
        .idx(thresh_idx)
    );

    sc_commit_queue #(
        .ENTRIES(COMMIT_ENTRIES),
        .TAG_WIDTH(THRESH_IDX_WIDTH),
        .payload_t(thresh_row_t)
    ) u_thresh_queue (
        .clk(clk),
        .rst(rst),
        .we(|train),
        .wtag(thresh_idx),
        .wdata(thresh_new),
        .rtag(thresh_idx),
        .rhit(thresh_hit),
        .rdata(thresh_cq_row)
    );

    assign thresh_base = thresh_hit ? thresh_cq_row : update_meta.thresh_ctr;

    always_comb begin
        for (int s = 0; s < SLOT_NUM; s++) begin
            thresh_new[s] = train[s] ? thresh_step(thresh_base[s], pred_error[s]) : thresh_base[s];
        end
    end

    assign upd.thresh_idx = thresh_idx;
    assign upd.thresh_row = thresh_new;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int s = 0; s < SLOT_NUM; s++) begin
                gthresh[s] <= gthresh_ctr_t'(GTHRESH_INIT);
            end
        end else begin
            for (int s = 0; s < SLOT_NUM; s++) begin
                if (train[s]) begin
                    gthresh[s] <= gthresh_step(gthresh[s], pred_error[s]);
                end
            end
        end
    end

endmodule

/* sc_predict.sv */
`timescale 1ns/100ps

module sc_predict (
    input logic clk,
    input logic rst,
    input logic stall,
    input sc_pkg::ctr_row_t [sc_pkg::TABLE_NUM-1:0] ctr_rows,
    input sc_pkg::thresh_row_t thresh_row,
    input sc_pkg::gthresh_row_t gthresh,
    input logic [sc_pkg::SLOT_NUM-1:0][sc_pkg::TAGE_CTR_SIZE-1:0] tage_ctr,
    input logic [sc_pkg::SLOT_NUM-1:0] tage_taken,
    output logic [sc_pkg::SLOT_NUM-1:0] prediction,
    output sc_pkg::sc_meta_t meta
);
    import sc_pkg::*;

    localparam int LT_WIDTH = THRESH_CTR + 1; // per-PC plus global threshold can carry.
    localparam logic [TAGE_CTR_SIZE-1:0] WEAK = TAGE_CTR_SIZE'(TAGE_WEAK_TAKEN);

    logic [SUM_WIDTH-1:0] sum [SLOT_NUM];
    logic [SUM_WIDTH-1:0] mag [SLOT_NUM];
    logic [SLOT_NUM-1:0] sc_taken;
    logic [SLOT_NUM-1:0] thresh_update;
    logic [SLOT_NUM-1:0] pred_next;

    always_comb begin
        ctr_t c;
        logic [CTR_SIZE-1:0] c_mag;
        for (int s = 0; s < SLOT_NUM; s++) begin
            sum[s] = '0;
            mag[s] = '0;
            for (int t = 0; t < TABLE_NUM; t++) begin
                c = ctr_rows[t][s];
                c_mag = c[CTR_SIZE-1] ? ~c : c; // -c-1 is the bitwise inverse.
                sum[s] = sum[s] + {{(SUM_WIDTH-CTR_SIZE){c[CTR_SIZE-1]}}, c};
                mag[s] = mag[s] + {{(SUM_WIDTH-CTR_SIZE){1'b0}}, c_mag};
            end
        end
    end

    for (genvar s = 0; s < SLOT_NUM; s++) begin : g_slot
        logic [LT_WIDTH-1:0] lt;
        logic [LT_WIDTH-1:0] mag_ext;
        logic low_conf;
        logic mid_conf;
        logic use_sc;

        assign sc_taken[s] = ~sum[s][SUM_WIDTH-1];
        assign lt = LT_WIDTH'(thresh_row[s]) + LT_WIDTH'(gthresh[s]);
        assign mag_ext = LT_WIDTH'(mag[s]);

        // confidence bands sit symmetrically around the weak-taken value.
        assign low_conf = (tage_ctr[s] == WEAK) || (tage_ctr[s] == WEAK - 1'b1);
        assign mid_conf = (tage_ctr[s] == WEAK + 1'b1) || (tage_ctr[s] == WEAK - 2'd2);

        assign use_sc = low_conf ||
                        (mid_conf && (mag_ext > (lt >> 2))) ||
                        (!low_conf && !mid_conf && (mag_ext > (lt >> 1)));

        assign pred_next[s] = use_sc ? sc_taken[s] : tage_taken[s];
        assign thresh_update[s] = mag_ext < lt;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prediction <= '0;
            meta <= '0;
        end else if (!stall) begin
            prediction <= pred_next;
            meta.ctrs <= ctr_rows;
            meta.pred_taken <= sc_taken;
            meta.thresh_ctr <= thresh_row;
            meta.thresh_update <= thresh_update;
        end
    end

endmodule

/* sc_commit_queue.sv */
`timescale 1ns/100ps

module sc_commit_queue #(
    parameter int ENTRIES = 4,
    parameter int TAG_WIDTH = 6,
    parameter type payload_t = logic
) (
    input logic clk,
    input logic rst,
    input logic we,
    input logic [TAG_WIDTH-1:0] wtag,
    input payload_t wdata,
    input logic [TAG_WIDTH-1:0] rtag,
    output logic rhit,
    output payload_t rdata
);
    localparam int PTR_WIDTH = (ENTRIES > 1) ? $clog2(ENTRIES) : 1;

    logic [PTR_WIDTH-1:0] wptr; // points at the oldest slot once the queue is full.
    logic [ENTRIES-1:0] valid;
    logic [TAG_WIDTH-1:0] tags [ENTRIES];
    payload_t data [ENTRIES];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wptr <= '0;
            valid <= '0;
        end else if (we) begin
            valid[wptr] <= 1'b1;
            wptr <= (wptr == PTR_WIDTH'(ENTRIES - 1)) ? '0 : wptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            tags[wptr] <= wtag;
            data[wptr] <= wdata;
        end
    end

    // walk from the oldest entry to the newest, so the last match wins.
    always_comb begin
        int slot;
        rhit = 1'b0;
        rdata = data[0];
        for (int k = 0; k < ENTRIES; k++) begin
            slot = (int'(wptr) + k) % ENTRIES;
            if (valid[slot] && tags[slot] == rtag) begin
                rhit = 1'b1;
                rdata = data[slot];
            end
        end
    end

endmodule

/* sc_table.sv */
`timescale 1ns/100ps

module sc_table #(
    parameter int DEPTH = 64,
    parameter type row_t = logic,
    parameter row_t RESET_VALUE = '0,
    parameter int TABLE_SEL = 0
) (
    input logic clk,
    input logic rst,
    input logic en,
    input logic [$clog2(DEPTH)-1:0] lookup_idx,
    output row_t lookup_row,
    sc_update_if.tables upd
);
    import sc_pkg::*;

    localparam int IDX_WIDTH = $clog2(DEPTH);

    row_t mem [DEPTH];
    logic [IDX_WIDTH-1:0] wr_idx;
    row_t wr_row;
    logic wr_en;

    // the selector one past the last counter table means the threshold table.
    if (TABLE_SEL < TABLE_NUM) begin : g_ctr_port
        assign wr_idx = upd.tbl_idx[TABLE_SEL];
        assign wr_row = upd.tbl_row[TABLE_SEL];
    end else begin : g_thresh_port
        assign wr_idx = upd.thresh_idx;
        assign wr_row = upd.thresh_row;
    end

    assign wr_en = |upd.slot_en;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= RESET_VALUE;
            end
            lookup_row <= RESET_VALUE;
        end else begin
            if (wr_en) begin
                mem[wr_idx] <= wr_row;
            end
            if (en) begin
                lookup_row <= mem[lookup_idx]; // a same-edge write is seen one cycle later.
            end
        end
    end

endmodule

/* sc_index.sv */
`timescale 1ns/100ps

module sc_index #(
    parameter int IDX_WIDTH = 6,
    parameter int HIST_LEN = 0
) (
    input logic [sc_pkg::VADDR_SIZE-1:0] pc,
    input logic [sc_pkg::GHIST_WIDTH-1:0] ghist,
    output logic [IDX_WIDTH-1:0] idx
);
    import sc_pkg::*;

    logic [IDX_WIDTH-1:0] pc_hash;

    assign pc_hash = pc[INST_OFFSET +: IDX_WIDTH] ^ pc[INST_OFFSET + IDX_WIDTH +: IDX_WIDTH];

    if (HIST_LEN == 0) begin : g_pc_only
        assign idx = pc_hash;
    end else if (HIST_LEN < 2 * IDX_WIDTH) begin : g_short
        // the history is laid once against the low end and once against the high end.
        logic [HIST_LEN+IDX_WIDTH-1:0] at_low;
        logic [HIST_LEN+IDX_WIDTH-1:0] at_high;
        assign at_low = (HIST_LEN + IDX_WIDTH)'(ghist[HIST_LEN-1:0]);
        assign at_high = {ghist[HIST_LEN-1:0], {IDX_WIDTH{1'b0}}};
        assign idx = pc_hash ^ at_low[IDX_WIDTH-1:0] ^ at_high[HIST_LEN+IDX_WIDTH-1 -: IDX_WIDTH];
    end else begin : g_folded
        localparam int CHUNKS = (HIST_LEN + IDX_WIDTH - 1) / IDX_WIDTH;
        logic [CHUNKS*IDX_WIDTH-1:0] padded; // the remainder lands zero-extended in the top chunk.
        logic [IDX_WIDTH-1:0] folded;
        assign padded = (CHUNKS * IDX_WIDTH)'(ghist[HIST_LEN-1:0]);
        always_comb begin
            folded = '0;
            for (int k = 0; k < CHUNKS; k++) begin
                folded = folded ^ padded[k*IDX_WIDTH +: IDX_WIDTH];
            end
        end
        assign idx = pc_hash ^ folded;
    end

endmodule

/* sc_update_if.sv */
`timescale 1ns/100ps

interface sc_update_if;
    import sc_pkg::*;

    logic [SLOT_NUM-1:0] slot_en; // any set bit writes the whole row.
    logic [TABLE_NUM-1:0][TABLE_IDX_WIDTH-1:0] tbl_idx;
    ctr_row_t [TABLE_NUM-1:0] tbl_row;
    logic [THRESH_IDX_WIDTH-1:0] thresh_idx;
    thresh_row_t thresh_row;

    modport updater (
        output slot_en,
        output tbl_idx,
        output tbl_row,
        output thresh_idx,
        output thresh_row
    );

    modport tables (
        input slot_en,
        input tbl_idx,
        input tbl_row,
        input thresh_idx,
        input thresh_row
    );

endinterface

/* sc_pkg.sv */
package sc_pkg;

    // fetch block geometry and counter widths.
    localparam int SLOT_NUM = 2;
    localparam int CTR_SIZE = 6;
    localparam int TABLE_NUM = 3;
    localparam int TABLE_IDX_WIDTH = 6;
    localparam int HIST_LEN [TABLE_NUM] = '{0, 8, 16}; // table 0 is the bias table.
    localparam int GHIST_WIDTH = 16;
    localparam int VADDR_SIZE = 32;
    localparam int INST_OFFSET = 1;

    localparam int THRESH_CTR = 8;
    localparam int THRESH_IDX_WIDTH = 4;
    localparam int GTHRESH_CTR = 6;
    localparam int GTHRESH_INIT = 24;

    localparam int TAGE_CTR_SIZE = 3;
    localparam int TAGE_WEAK_TAKEN = 1 << (TAGE_CTR_SIZE - 1);

    // wide enough for three magnitudes or three signed counters.
    localparam int SUM_WIDTH = 8;

    typedef logic signed [CTR_SIZE-1:0] ctr_t;
    typedef ctr_t [SLOT_NUM-1:0] ctr_row_t;

    typedef logic [THRESH_CTR-1:0] thresh_ctr_t;
    typedef thresh_ctr_t [SLOT_NUM-1:0] thresh_row_t;

    typedef logic [GTHRESH_CTR-1:0] gthresh_ctr_t;
    typedef gthresh_ctr_t [SLOT_NUM-1:0] gthresh_row_t;

    // state seen at lookup, carried back with the branch to commit.
    typedef struct packed {
        ctr_row_t [TABLE_NUM-1:0] ctrs;
        logic [SLOT_NUM-1:0] pred_taken;
        thresh_row_t thresh_ctr;
        logic [SLOT_NUM-1:0] thresh_update;
    } sc_meta_t;

endpackage
